/* flist.f */
+incdir+include
verilog/ad7768_pkg.sv
verilog/ad7768_lane_deser.sv
verilog/ad7768_crc4.sv
verilog/ad7768_if.sv
verilog/ad7768_regs.sv
verilog/ad7768_capture_top.sv
sim/ad7768_asserts.sv
sim/ad7768_tb.sv

/* Bender.yml */
package:
  name: ad7768_capture

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/ad7768_pkg.sv
      - verilog/ad7768_lane_deser.sv
      - verilog/ad7768_crc4.sv
      - verilog/ad7768_if.sv
      - verilog/ad7768_regs.sv
      - verilog/ad7768_capture_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/ad7768_asserts.sv
      - sim/ad7768_tb.sv

/* sim/ad7768_tb.sv */
// ****************************************
// AD7768 capture testbench
// Table of lane formats and header faults
// run through the converter lanes and APB
// ****************************************

`timescale 1ns/10ps

`include "ad7768_consts.svh"

module ad7768_tb;

  localparam int NL            = `AD7768_NUM_LANES;
  localparam int WB            = `AD7768_WORD_BITS;
  localparam int NUM_ROWS      = 8;
  localparam int VALID_TIMEOUT = 50;
  localparam int QUIET_CYCLES  = 40;

  logic          clk;
  logic          arst_n;
  logic          ready;
  logic [NL-1:0] data;
  logic [7:0]    paddr;
  logic          psel;
  logic          penable;
  logic          pwrite;
  logic [31:0]   pwdata;
  logic [31:0]   prdata;
  logic          adc_valid;
  logic [2:0]    adc_chan;
  logic [23:0]   adc_data;
  logic [3:0]    adc_flags;

  // Stimulus table, one entry per test row
  string         row_name  [NUM_ROWS];
  logic [1:0]    row_fmt   [NUM_ROWS];
  logic          row_crc   [NUM_ROWS];
  logic          row_sshot [NUM_ROWS];
  logic [7:0]    row_bad   [NUM_ROWS];
  logic [7:0]    row_hdr   [NUM_ROWS];

  logic [23:0]   sample_tab  [NL];
  logic [3:0]    flag_tab    [NL];
  logic [WB-1:0] frame_words [NL];
  logic [15:0]   exp_count;

  ad7768_capture_top dut (
    .clk_in      (clk),
    .arst_n_i    (arst_n),
    .ready_in    (ready),
    .data_in     (data),
    .paddr_i     (paddr),
    .psel_i      (psel),
    .penable_i   (penable),
    .pwrite_i    (pwrite),
    .pwdata_i    (pwdata),
    .prdata_o    (prdata),
    .adc_valid_o (adc_valid),
    .adc_chan_o  (adc_chan),
    .adc_data_o  (adc_data),
    .adc_flags_o (adc_flags)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    if (dut.i_asserts.fail_cnt != 0) begin
      $display("A bound assertion failed");
      $display("** FAIL **");
      $fatal(1, "Stopped on an assertion failure");
    end
  end

  // ****************************************
  // Helpers
  // ****************************************

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      $display("[FAIL] %s: expected 0x%0h, actual 0x%0h", name, exp, act);
      $display("** FAIL **");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("Timed out waiting for output words in %s", what);
    $display("** FAIL **");
    $fatal(1, "Stopped on a timeout");
  endtask

  // CRC-4, x^4+x+1, seed all ones, sample bits MSB first
  function automatic logic [3:0] crc4_of(input logic [23:0] s);
    logic [3:0] r;
    logic       msb;
    r = `AD7768_CRC_SEED;
    for (int b = 23; b >= 0; b--) begin
      msb = r[3] ^ s[b];
      r   = {r[2:0], 1'b0};
      if (msb) begin
        r = r ^ 4'h3;
      end
    end
    return r;
  endfunction

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] wdata);
    @(negedge clk);
    paddr   = addr;
    pwdata  = wdata;
    pwrite  = 1'b1;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic read_reg(input logic [7:0] addr, output logic [31:0] rdata);
    @(negedge clk);
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    rdata   = prdata;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic set_row(input int i, input string name, input logic [1:0] fmt,
                         input logic crc, input logic sshot, input logic [7:0] bad,
                         input logic [7:0] hdr);
    row_name[i]  = name;
    row_fmt[i]   = fmt;
    row_crc[i]   = crc;
    row_sshot[i] = sshot;
    row_bad[i]   = bad;
    row_hdr[i]   = hdr;
  endtask

  // Header is error bit, channel id and nibble, then the sample
  task automatic build_frame(input logic crc_en, input logic [7:0] bad,
                             input logic [7:0] hdr);
    logic [3:0] nib;
    for (int ch = 0; ch < NL; ch++) begin
      if (crc_en) begin
        nib = crc4_of(sample_tab[ch]) ^ (bad[ch] ? 4'h5 : 4'h0);
      end else begin
        nib = flag_tab[ch];
      end
      frame_words[ch] = {hdr[ch], 3'(ch), nib, sample_tab[ch]};
    end
  endtask

  // Lane k carries channels k, k+L and so on, each word MSB first
  task automatic send_frame(input logic [1:0] fmt);
    int lanes;
    int n;
    int b;
    lanes = NL >> fmt;
    for (int c = 0; c < WB * (NL / lanes); c++) begin
      @(negedge clk);
      ready = (c == 0);
      n     = c / WB;
      b     = WB - 1 - (c % WB);
      for (int k = 0; k < NL; k++) begin
        data[k] = (k < lanes) ? frame_words[k + n * lanes][b] : 1'b0;
      end
    end
    @(negedge clk);
    ready = 1'b0;
    data  = '0;
  endtask

  task automatic collect_frame(input string name, input logic crc_en);
    int n;
    n = 0;
    while (adc_valid !== 1'b1) begin
      if (n == VALID_TIMEOUT) begin
        fail_timeout(name);
      end
      n++;
      @(negedge clk);
    end
    // Channels leave back to back in ascending order
    for (int ch = 0; ch < NL; ch++) begin
      check_value($sformatf("%s ch%0d valid", name, ch), 1, adc_valid);
      check_value($sformatf("%s ch%0d chan", name, ch), ch, adc_chan);
      check_value($sformatf("%s ch%0d data", name, ch), sample_tab[ch], adc_data);
      check_value($sformatf("%s ch%0d flags", name, ch),
                  crc_en ? 4'h0 : flag_tab[ch], adc_flags);
      @(negedge clk);
    end
  endtask

  task automatic expect_quiet(input string name);
    for (int i = 0; i < QUIET_CYCLES; i++) begin
      @(negedge clk);
      check_value({name, " no output"}, 0, adc_valid);
    end
  endtask

  // ****************************************
  // One table row
  // ****************************************

  task automatic run_row(input int i);
    logic [31:0] ctrl;
    logic [31:0] rd;
    logic [16:0] exp_status;
    logic [16:0] clr;
    string       name;
    name       = row_name[i];
    ctrl       = {27'd0, row_sshot[i], row_crc[i], row_fmt[i], 1'b1};
    exp_status = {|row_hdr[i], 8'h00, row_crc[i] ? row_bad[i] : 8'h00};
    write_reg(`AD7768_REG_STATUS, 32'h0001_FFFF);
    write_reg(`AD7768_REG_CTRL, ctrl | (32'(row_sshot[i]) << 5));
    read_reg(`AD7768_REG_CTRL, rd);
    check_value({name, " ctrl"}, ctrl, rd);
    build_frame(row_crc[i], row_bad[i], row_hdr[i]);
    send_frame(row_fmt[i]);
    collect_frame(name, row_crc[i]);
    exp_count++;
    read_reg(`AD7768_REG_COUNT, rd);
    check_value({name, " count"}, exp_count, rd);
    read_reg(`AD7768_REG_STATUS, rd);
    check_value({name, " status"}, exp_status, rd);
    if (exp_status != 17'd0) begin
      // Clear the lowest set bit only, the rest must stay
      clr = exp_status & (~exp_status + 17'd1);
      write_reg(`AD7768_REG_STATUS, 32'(clr));
      read_reg(`AD7768_REG_STATUS, rd);
      check_value({name, " status partial clear"}, exp_status & ~clr, rd);
    end
    if (row_sshot[i]) begin
      send_frame(row_fmt[i]);
      expect_quiet({name, " unarmed"});
      read_reg(`AD7768_REG_COUNT, rd);
      check_value({name, " unarmed count"}, exp_count, rd);
      write_reg(`AD7768_REG_CTRL, ctrl | 32'h20);
      send_frame(row_fmt[i]);
      collect_frame({name, " rearmed"}, row_crc[i]);
      exp_count++;
      read_reg(`AD7768_REG_COUNT, rd);
      check_value({name, " rearmed count"}, exp_count, rd);
    end
  endtask

  // ****************************************
  // Main sequence
  // ****************************************

  initial begin
    logic [31:0] rd;
    void'($urandom(72));
    arst_n    = 1'b0;
    ready     = 1'b0;
    data      = '0;
    paddr     = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = '0;
    exp_count = '0;
    for (int ch = 0; ch < NL; ch++) begin
      sample_tab[ch] = 24'($urandom);
      flag_tab[ch]   = 4'($urandom);
    end
    set_row(0, "fmt8_plain", 2'd0, 1'b0, 1'b0, 8'h00, 8'h00);
    set_row(1, "fmt4_plain", 2'd1, 1'b0, 1'b0, 8'h00, 8'h00);
    set_row(2, "fmt2_plain", 2'd2, 1'b0, 1'b0, 8'h00, 8'h00);
    set_row(3, "fmt1_plain", 2'd3, 1'b0, 1'b0, 8'h00, 8'h00);
    set_row(4, "fmt8_crc_bad", 2'd0, 1'b1, 1'b0, 8'h24, 8'h00);
    set_row(5, "fmt2_crc_hdr", 2'd2, 1'b1, 1'b0, 8'h81, 8'h10);
    set_row(6, "fmt1_crc_good", 2'd3, 1'b1, 1'b0, 8'h00, 8'h00);
    set_row(7, "fmt4_sshot", 2'd1, 1'b1, 1'b1, 8'h02, 8'h00);

    repeat (8) @(negedge clk);
    arst_n = 1'b1;

    // Registers come out of reset at zero and a disabled block stays silent
    read_reg(`AD7768_REG_CTRL, rd);
    check_value("reset ctrl", 0, rd);
    read_reg(`AD7768_REG_STATUS, rd);
    check_value("reset status", 0, rd);
    read_reg(`AD7768_REG_COUNT, rd);
    check_value("reset count", 0, rd);
    build_frame(1'b0, 8'h00, 8'h00);
    send_frame(2'd0);
    expect_quiet("disabled");

    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i);
    end

    if (dut.i_asserts.fail_cnt == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("** FAIL **");
      $fatal(1, "Stopped on an assertion failure");
    end
  end

endmodule

/* sim/ad7768_asserts.sv */
// ****************************************
// AD7768 capture assertions
// Output word and APB protocol checks
// ****************************************

`timescale 1ns/10ps

module ad7768_asserts (
  input logic clk_in,
  input logic arst_n_i,
  input logic adc_valid_i,
  input logic frame_done_i,
  input logic psel_i,
  input logic penable_i
);

  logic [3:0] vld_cnt;
  int         fail_cnt = 0;

  // Words seen since the last frame-done pulse, channel 7 shares its cycle
  always_ff @(posedge clk_in or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vld_cnt <= '0;
    end else if (frame_done_i) begin
      vld_cnt <= '0;
    end else if (adc_valid_i && (vld_cnt != 4'hF)) begin
      vld_cnt <= vld_cnt + 4'd1;
    end
  end

  valid_in_reset: assert property (@(posedge clk_in) !arst_n_i |-> !adc_valid_i)
    else begin
      $error("adc_valid_o high during reset");
      fail_cnt++;
    end

  words_per_set: assert property (@(posedge clk_in) disable iff (!arst_n_i)
    adc_valid_i |-> (vld_cnt < 4'd8))
    else begin
      $error("More than eight output words between frame-done pulses");
      fail_cnt++;
    end

  penable_needs_psel: assert property (@(posedge clk_in) disable iff (!arst_n_i)
    penable_i |-> psel_i)
    else begin
      $error("penable high without psel");
      fail_cnt++;
    end

  penable_after_setup: assert property (@(posedge clk_in) disable iff (!arst_n_i)
    $rose(penable_i) |-> $past(psel_i))
    else begin
      $error("penable rose without a setup phase");
      fail_cnt++;
    end

endmodule

// The APB pins live at the top level, next to the interface outputs
bind ad7768_capture_top ad7768_asserts i_asserts (
  .clk_in       (clk_in),
  .arst_n_i     (arst_n_i),
  .adc_valid_i  (adc_valid_o),
  .frame_done_i (frame_done),
  .psel_i       (psel_i),
  .penable_i    (penable_i)
);

/* verilog/ad7768_capture_top.sv */
// ****************************************
// AD7768 capture top level
// Converter interface plus APB registers
// ****************************************

`timescale 1ns/10ps

`include "ad7768_consts.svh"

module ad7768_capture_top (
  input  logic                         clk_in,
  input  logic                         arst_n_i,
  input  logic                         ready_in,
  input  logic [`AD7768_NUM_LANES-1:0] data_in,
  input  logic [7:0]                   paddr_i,
  input  logic                         psel_i,
  input  logic                         penable_i,
  input  logic                         pwrite_i,
  input  logic [31:0]                  pwdata_i,
  output logic [31:0]                  prdata_o,
  output logic                         adc_valid_o,
  output logic [2:0]                   adc_chan_o,
  output logic [23:0]                  adc_data_o,
  output logic [3:0]                   adc_flags_o
);

  import ad7768_pkg::*;

  logic           enable;
  ad7768_format_e format;
  logic           crc_en;
  logic           sshot;
  logic           arm;
  logic [16:0]    status_clr;
  logic [16:0]    status;
  logic           frame_done;

  ad7768_if i_ad7768_if (
    .clk_in       (clk_in),
    .arst_n_i     (arst_n_i),
    .ready_in     (ready_in),
    .data_in      (data_in),
    .enable_i     (enable),
    .format_i     (format),
    .crc_en_i     (crc_en),
    .sshot_i      (sshot),
    .arm_i        (arm),
    .status_clr_i (status_clr),
    .status_o     (status),
    .frame_done_o (frame_done),
    .adc_valid_o  (adc_valid_o),
    .adc_chan_o   (adc_chan_o),
    .adc_data_o   (adc_data_o),
    .adc_flags_o  (adc_flags_o)
  );

  ad7768_regs i_ad7768_regs (
    .clk_in       (clk_in),
    .arst_n_i     (arst_n_i),
    .paddr_i      (paddr_i),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .pwdata_i     (pwdata_i),
    .prdata_o     (prdata_o),
    .status_i     (status),
    .frame_done_i (frame_done),
    .enable_o     (enable),
    .format_o     (format),
    .crc_en_o     (crc_en),
    .sshot_o      (sshot),
    .arm_o        (arm),
    .status_clr_o (status_clr)
  );

endmodule

/* verilog/ad7768_regs.sv */
// ****************************************
// AD7768 register block
// APB slave for control, status and the
// frame set counter
// ****************************************

`timescale 1ns/10ps

`include "ad7768_consts.svh"

module ad7768_regs (
  input  logic                       clk_in,
  input  logic                       arst_n_i,
  input  logic [7:0]                 paddr_i,
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  logic [31:0]                pwdata_i,
  output logic [31:0]                prdata_o,
  input  logic [16:0]                status_i,
  input  logic                       frame_done_i,
  output logic                       enable_o,
  output ad7768_pkg::ad7768_format_e format_o,
  output logic                       crc_en_o,
  output logic                       sshot_o,
  output logic                       arm_o,
  output logic [16:0]                status_clr_o
);

  import ad7768_pkg::*;

  logic        wr_en;
  logic        ctrl_wr;
  logic [15:0] frame_cnt;

  // Zero-wait slave, writes land in the access phase
  assign wr_en   = psel_i && penable_i && pwrite_i;
  assign ctrl_wr = wr_en && (paddr_i == `AD7768_REG_CTRL);

  // ****************************************
  // Control register
  // ****************************************

  always_ff @(posedge clk_in or negedge arst_n_i) begin
    if (!arst_n_i) begin
      enable_o <= 1'b0;
      format_o <= FMT_8LANE;
      crc_en_o <= 1'b0;
      sshot_o  <= 1'b0;
      arm_o    <= 1'b0;
    end else begin
      if (ctrl_wr) begin
        enable_o <= pwdata_i[0];
        format_o <= ad7768_format_e'(pwdata_i[2:1]);
        crc_en_o <= pwdata_i[3];
        sshot_o  <= pwdata_i[4];
      end
      // Arm is a one-cycle pulse and never reads back
      arm_o <= ctrl_wr && pwdata_i[5];
    end
  end

  // Write-one-to-clear goes straight to the sticky bits
  assign status_clr_o = (wr_en && (paddr_i == `AD7768_REG_STATUS)) ? pwdata_i[16:0] : '0;

  // Completed frame sets, wraps at 16 bits
  always_ff @(posedge clk_in or negedge arst_n_i) begin
    if (!arst_n_i) begin
      frame_cnt <= '0;
    end else if (frame_done_i) begin
      frame_cnt <= frame_cnt + 16'd1;
    end
  end

  // ****************************************
  // Read data
  // ****************************************

  always_comb begin
    case (paddr_i)
      `AD7768_REG_CTRL: begin
        prdata_o = {27'd0, sshot_o, crc_en_o, format_o, enable_o};
      end
      `AD7768_REG_STATUS: begin
        prdata_o = {15'd0, status_i};
      end
      `AD7768_REG_COUNT: begin
        prdata_o = {16'd0, frame_cnt};
      end
      default: begin
        prdata_o = '0;
      end
    endcase
  end

endmodule

/* verilog/ad7768_if.sv */
// ****************************************
// AD7768 converter interface
// Frame capture, lane reordering, header
// checks and sticky error status
// ****************************************

`timescale 1ns/10ps

`include "ad7768_consts.svh"

module ad7768_if (
  input  logic                       clk_in,
  input  logic                       arst_n_i,
  input  logic                       ready_in,
  input  logic [`AD7768_NUM_LANES-1:0] data_in,
  input  logic                       enable_i,
  input  ad7768_pkg::ad7768_format_e format_i,
  input  logic                       crc_en_i,
  input  logic                       sshot_i,
  input  logic                       arm_i,
  input  logic [16:0]                status_clr_i,
  output logic [16:0]                status_o,
  output logic                       frame_done_o,
  output logic                       adc_valid_o,
  output logic [2:0]                 adc_chan_o,
  output logic [23:0]                adc_data_o,
  output logic [3:0]                 adc_flags_o
);

  import ad7768_pkg::*;

  localparam int NL = `AD7768_NUM_LANES;

  logic [`AD7768_WORD_BITS-1:0] lane_word [NL];
  logic [NL-1:0]                lane_vld;
  logic [`AD7768_WORD_BITS-1:0] chan_buf [NL];
  logic [3:0]                   lanes_used;
  logic [2:0]                   words_last;
  logic                         active;
  logic                         armed;
  logic [2:0]                   word_cnt;
  logic                         set_last;
  logic                         drain_act;
  logic [2:0]                   rd_idx;
  ad7768_frame_u                rd_word;
  logic                         crc_ok;
  logic                         crc_fail;
  logic                         id_fail;
  logic [NL-1:0]                crc_acc;
  logic [NL-1:0]                id_acc;
  logic                         hdr_acc;
  logic [NL-1:0]                crc_new;
  logic [NL-1:0]                id_new;
  logic                         hdr_new;

  // ****************************************
  // Lane deserialisers
  // ****************************************

  for (genvar k = 0; k < NL; k++) begin : g_lane
    ad7768_lane_deser i_deser (
      .clk_in     (clk_in),
      .arst_n_i   (arst_n_i),
      .start_i    (ready_in),
      .bit_i      (data_in[k]),
      .word_o     (lane_word[k]),
      .word_vld_o (lane_vld[k])
    );
  end

  // Lanes in use and words per lane in one frame set
  always_comb begin
    case (format_i)
      FMT_4LANE: begin
        lanes_used = 4'd4;
        words_last = 3'd1;
      end
      FMT_2LANE: begin
        lanes_used = 4'd2;
        words_last = 3'd3;
      end
      FMT_1LANE: begin
        lanes_used = 4'd1;
        words_last = 3'd7;
      end
      default: begin
        lanes_used = 4'd8;
        words_last = 3'd0;
      end
    endcase
  end

  // All lanes run in lock step, lane 0 stands for the rest
  assign set_last = active && lane_vld[0] && (word_cnt == words_last);

  // ****************************************
  // Frame tracking and buffer drain
  // ****************************************

  always_ff @(posedge clk_in or negedge arst_n_i) begin
    if (!arst_n_i) begin
      active    <= 1'b0;
      armed     <= 1'b0;
      word_cnt  <= '0;
      drain_act <= 1'b0;
      rd_idx    <= '0;
    end else begin
      if (ready_in) begin
        // Single-shot only starts when armed, and the start uses up the arm
        active   <= enable_i && (!sshot_i || armed);
        word_cnt <= '0;
        if (enable_i && sshot_i && armed) begin
          armed <= 1'b0;
        end
      end else if (active && lane_vld[0]) begin
        if (word_cnt == words_last) begin
          active <= 1'b0;
        end else begin
          word_cnt <= word_cnt + 3'd1;
        end
      end
      if (arm_i) begin
        armed <= 1'b1;
      end

      if (set_last) begin
        drain_act <= 1'b1;
        rd_idx    <= '0;
      end else if (drain_act) begin
        rd_idx <= rd_idx + 3'd1;
        if (rd_idx == 3'd7) begin
          drain_act <= 1'b0;
        end
      end
    end
  end

  // Lane k word n lands in channel slot k + n*L
  always_ff @(posedge clk_in) begin
    if (active) begin
      for (int k = 0; k < NL; k++) begin
        if (lane_vld[k] && (k < lanes_used)) begin
          chan_buf[3'(k + int'(word_cnt) * int'(lanes_used))] <= lane_word[k];
        end
      end
    end
  end

  // ****************************************
  // Header checks and output
  // ****************************************

  assign rd_word = chan_buf[rd_idx];

  ad7768_crc4 i_crc4 (
    .sample_i (rd_word.crc.sample),
    .crc_i    (rd_word.crc.crc),
    .crc_ok_o (crc_ok)
  );

  assign crc_fail = crc_en_i && !crc_ok;
  assign id_fail  = (rd_word.crc.chan_id != rd_idx);
  assign crc_new  = crc_acc | ({{(NL-1){1'b0}}, crc_fail} << rd_idx);
  assign id_new   = id_acc | ({{(NL-1){1'b0}}, id_fail} << rd_idx);
  assign hdr_new  = hdr_acc | rd_word.crc.err;

  // Errors of a frame set reach the sticky status together with channel 7
  always_ff @(posedge clk_in or negedge arst_n_i) begin
    if (!arst_n_i) begin
      adc_valid_o  <= 1'b0;
      frame_done_o <= 1'b0;
      status_o     <= '0;
      crc_acc      <= '0;
      id_acc       <= '0;
      hdr_acc      <= 1'b0;
    end else begin
      adc_valid_o  <= drain_act;
      frame_done_o <= drain_act && (rd_idx == 3'd7);
      if (drain_act && (rd_idx == 3'd7)) begin
        status_o <= (status_o & ~status_clr_i) | {hdr_new, id_new, crc_new};
        crc_acc  <= '0;
        id_acc   <= '0;
        hdr_acc  <= 1'b0;
      end else begin
        status_o <= status_o & ~status_clr_i;
        if (drain_act) begin
          crc_acc <= crc_new;
          id_acc  <= id_new;
          hdr_acc <= hdr_new;
        end
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (drain_act) begin
      adc_chan_o  <= rd_idx;
      adc_data_o  <= rd_word.crc.sample;
      // The nibble only means status flags with CRC off
      adc_flags_o <= crc_en_i ? 4'h0 : rd_word.stat.flags;
    end
  end

endmodule

/* verilog/ad7768_crc4.sv */
// ****************************************
// AD7768 CRC-4 check
// x^4+x+1 over the 24 sample bits
// ****************************************

`timescale 1ns/10ps

`include "ad7768_consts.svh"

module ad7768_crc4 (
  input  logic [23:0] sample_i,
  input  logic [3:0]  crc_i,
  output logic        crc_ok_o
);

  logic [3:0] crc_calc;

  // Bit-serial LFSR unrolled over the sample, MSB first
  always_comb begin
    logic fb;
    crc_calc = `AD7768_CRC_SEED;
    for (int i = 23; i >= 0; i--) begin
      fb       = crc_calc[3] ^ sample_i[i];
      crc_calc = {crc_calc[2:0], 1'b0} ^ {2'b00, fb, fb};
    end
  end

  assign crc_ok_o = (crc_calc == crc_i);

endmodule

/* verilog/ad7768_lane_deser.sv */
// ****************************************
// AD7768 lane deserialiser
// Shifts one serial lane into channel words
// ****************************************

`timescale 1ns/10ps

`include "ad7768_consts.svh"

module ad7768_lane_deser (
  input  logic                         clk_in,
  input  logic                         arst_n_i,
  input  logic                         start_i,
  input  logic                         bit_i,
  output logic [`AD7768_WORD_BITS-1:0] word_o,
  output logic                         word_vld_o
);

  localparam int CNT_W = $clog2(`AD7768_WORD_BITS);

  logic [CNT_W-1:0] bit_cnt;

  // The start strobe marks the first bit, so the counter resumes at one
  always_ff @(posedge clk_in or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bit_cnt    <= '0;
      word_vld_o <= 1'b0;
    end else begin
      if (start_i) begin
        bit_cnt    <= CNT_W'(1);
        word_vld_o <= 1'b0;
      end else begin
        bit_cnt    <= bit_cnt + CNT_W'(1);
        // Strobe together with the shift that takes in the last bit
        word_vld_o <= (bit_cnt == CNT_W'(`AD7768_WORD_BITS - 1));
      end
    end
  end

  // MSB arrives first and ends up at the top of the word
  always_ff @(posedge clk_in) begin
    word_o <= {word_o[`AD7768_WORD_BITS-2:0], bit_i};
  end

endmodule

/* verilog/ad7768_pkg.sv */
// ****************************************
// AD7768 capture types
// Lane format and the channel word layout
// ****************************************

package ad7768_pkg;

  // Number of lanes in use, L = 8 >> format
  typedef enum logic [1:0] {
    FMT_8LANE = 2'd0,
    FMT_4LANE = 2'd1,
    FMT_2LANE = 2'd2,
    FMT_1LANE = 2'd3
  } ad7768_format_e;

  // Header nibble carries a CRC-4 when CRC is on
  typedef struct packed {
    logic        err;
    logic [2:0]  chan_id;
    logic [3:0]  crc;
    logic [23:0] sample;
  } ad7768_crc_view_t;

  // Same nibble holds converter status flags when CRC is off
  typedef struct packed {
    logic        err;
    logic [2:0]  chan_id;
    logic [3:0]  flags;
    logic [23:0] sample;
  } ad7768_stat_view_t;

  typedef union packed {
    ad7768_crc_view_t  crc;
    ad7768_stat_view_t stat;
  } ad7768_frame_u;

endpackage

/* include/ad7768_consts.svh */
// ****************************************
// AD7768 capture constants
// Lane count, word size, CRC seed and the
// APB register map
// ****************************************

`ifndef AD7768_CONSTS_SVH
`define AD7768_CONSTS_SVH

// ****************************************
// Converter interface
// ****************************************

// Eight data lanes, one channel per lane in the widest format
`define AD7768_NUM_LANES 8

// Channel word is header plus sample, sent MSB first
`define AD7768_WORD_BITS 32

// CRC-4 register starts from all ones
`define AD7768_CRC_SEED 4'hF

// ****************************************
// APB register offsets
// ****************************************

`define AD7768_REG_CTRL   8'h00
`define AD7768_REG_STATUS 8'h04
`define AD7768_REG_COUNT  8'h08

`endif
